// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - logic/memPkg.sv
  - logic/byteRam.sv
  - logic/memCtrl.sv
  - logic/fetchUnit.sv
  - logic/instQueue.sv
  - logic/memSubsystem.sv
  - target: test
    files:
      - testbench/tbMemSubsystem.sv

// ==== logic/byteRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteRam
    import memPkg::*;
(
    input  logic       clk,
    input  memPort_t   i_port,
    output logic [7:0] o_rdByte
);

    logic [7:0] mem [RAM_DEPTH];

    // read-before-write, the old byte comes back on a write cycle
    always_ff @(posedge clk) begin
        if (i_port.wrEn) begin
            mem[i_port.addr] <= i_port.wrByte;
        end
        o_rdByte <= mem[i_port.addr];
    end

endmodule

`default_nettype wire

// ==== logic/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
    import memPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_fetchStart,
    input  logic [ADDR_WIDTH-1:0]   i_fetchPc,
    input  logic                    i_fetchDone,
    input  logic [31:0]             i_fetchInst,
    input  logic [QCOUNT_WIDTH-1:0] i_queueCount,
    output logic                    o_fetchReq,
    output logic [ADDR_WIDTH-1:0]   o_fetchAddr,
    output logic                    o_instPush,
    output logic [31:0]             o_instData,
    output logic                    o_queueFlush
);

    logic [ADDR_WIDTH-1:0] pc;
    logic                  enabled;
    // result of the in-flight fetch belongs to the old stream
    logic                  discard;
    logic                  canIssue;

    assign canIssue = enabled && !o_fetchReq && !i_fetchStart
                      && (i_queueCount < QCOUNT_WIDTH'(QUEUE_DEPTH));

    assign o_instPush = i_fetchDone && !discard && !i_fetchStart;
    assign o_instData = i_fetchInst;
    assign o_queueFlush = i_fetchStart;
    assign o_fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            enabled <= 1'b0;
            o_fetchReq <= 1'b0;
            discard <= 1'b0;
        end else begin
            if (i_fetchStart) begin
                enabled <= 1'b1;
            end
            if (i_fetchDone) begin
                o_fetchReq <= 1'b0;
                discard <= 1'b0;
            end else if (i_fetchStart && o_fetchReq) begin
                // request stays up until memCtrl finishes it
                discard <= 1'b1;
            end else if (canIssue) begin
                o_fetchReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetchStart) begin
            pc <= i_fetchPc;
        end else if (o_instPush) begin
            pc <= pc + ADDR_WIDTH'(4);
        end
    end

endmodule

`default_nettype wire

// ==== logic/instQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instQueue
    import memPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_push,
    input  logic [31:0]             i_pushData,
    input  logic                    i_pop,
    input  logic                    i_flush,
    output logic [31:0]             o_head,
    output logic                    o_valid,
    output logic [QCOUNT_WIDTH-1:0] o_count
);

    logic [31:0]           entries [QUEUE_DEPTH];
    logic [QPTR_WIDTH-1:0] rdPtr;
    logic [QPTR_WIDTH-1:0] wrPtr;
    logic                  full;
    logic                  doPush;
    logic                  doPop;

    assign full = (o_count == QCOUNT_WIDTH'(QUEUE_DEPTH));
    assign doPop = i_pop && o_valid;
    // a pop frees the slot in the same cycle
    assign doPush = i_push && (!full || doPop);

    assign o_head = entries[rdPtr];
    assign o_valid = (o_count != '0);

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            o_count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush && !i_flush) begin
            entries[wrPtr] <= i_pushData;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module memCtrl
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_ioFull,
    input  logic                  i_dataStb,
    input  dataReq_t              i_dataReq,
    input  logic                  i_fetchReq,
    input  logic [ADDR_WIDTH-1:0] i_fetchAddr,
    input  logic [7:0]            i_rdByte,
    output logic                  o_dataBusy,
    output dataResp_t             o_dataResp,
    output logic                  o_fetchDone,
    output logic [31:0]           o_fetchInst,
    output memPort_t              o_memPort
);

    ctrlState_e            state;
    logic [2:0]            stage;
    logic [2:0]            len;
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           wrData;
    // bytes 0..2 of a read, the last byte is merged on the fly
    logic [23:0]           asmWord;

    logic [2:0]            stageM1;
    logic [2:0]            byteIdx;
    logic [31:0]           word;
    logic                  isRead;
    logic                  lastRead;
    logic                  storeDone;
    logic                  accept;

    function automatic logic [2:0] widthLen(memWidth_e w);
        case (w)
            WIDTH_BYTE: return 3'd1;
            WIDTH_HALF: return 3'd2;
            default:    return 3'd4;
        endcase
    endfunction

    assign stageM1 = stage - 3'd1;
    assign isRead = (state == ST_LOAD) || (state == ST_FETCH);
    assign lastRead = isRead && (stage == len) && !i_ioFull;
    assign storeDone = (state == ST_STORE) && (stage == stageLast()) && !i_ioFull;
    assign accept = (state == ST_IDLE) && !i_ioFull && (i_dataStb || i_fetchReq);

    function automatic logic [2:0] stageLast();
        return len - 3'd1;
    endfunction

    // during a stall the previous address is re-read so the RAM output holds
    always_comb begin
        byteIdx = stage;
        if ((i_ioFull || stage == len) && stage != 3'd0) begin
            byteIdx = stageM1;
        end
    end

    always_comb begin
        case (len)
            3'd1:    word = {24'h0, i_rdByte};
            3'd2:    word = {16'h0, i_rdByte, asmWord[7:0]};
            default: word = {i_rdByte, asmWord};
        endcase
    end

    always_comb begin
        o_memPort.wrEn = (state == ST_STORE) && !i_ioFull;
        o_memPort.addr = addr + {{(ADDR_WIDTH - 3){1'b0}}, byteIdx};
        o_memPort.wrByte = wrData[{stage[1:0], 3'b000} +: 8];
    end

    assign o_dataBusy = (state != ST_IDLE) || i_ioFull;
    assign o_dataResp.done = (lastRead && state == ST_LOAD) || storeDone;
    assign o_dataResp.rdData = (lastRead && state == ST_LOAD) ? word : 32'h0;
    assign o_fetchDone = lastRead && (state == ST_FETCH);
    assign o_fetchInst = word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            stage <= 3'd0;
        end else if (!i_ioFull) begin
            case (state)
                ST_IDLE: begin
                    stage <= 3'd0;
                    // data wins over fetch
                    if (i_dataStb) begin
                        state <= (i_dataReq.op == OP_STORE) ? ST_STORE : ST_LOAD;
                    end else if (i_fetchReq) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH, ST_LOAD: begin
                    if (stage == len) begin
                        state <= ST_IDLE;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                ST_STORE: begin
                    if (stage == stageLast()) begin
                        state <= ST_IDLE;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (i_dataStb) begin
                addr <= i_dataReq.addr;
                len <= widthLen(i_dataReq.width);
                wrData <= i_dataReq.wrData;
            end else begin
                addr <= i_fetchAddr;
                len <= 3'd4;
            end
        end
        // byte for stage s was addressed one cycle earlier
        if (isRead && !i_ioFull && stage != 3'd0 && stage < len) begin
            asmWord[{stageM1[1:0], 3'b000} +: 8] <= i_rdByte;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memPkg.sv ====
`default_nettype none

package memPkg;

    localparam int ADDR_WIDTH = 12;
    localparam int RAM_DEPTH = 4096;
    localparam int QUEUE_DEPTH = 4;
    // queue pointer and occupancy widths
    localparam int QPTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QCOUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } memOp_e;

    typedef enum logic [1:0] {
        WIDTH_BYTE,
        WIDTH_HALF,
        WIDTH_WORD
    } memWidth_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_LOAD,
        ST_STORE
    } ctrlState_e;

    typedef struct packed {
        memOp_e                op;
        memWidth_e             width;
        logic [ADDR_WIDTH-1:0] addr;
        logic [31:0]           wrData;
    } dataReq_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdData;
    } dataResp_t;

    typedef struct packed {
        logic                  wrEn;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            wrByte;
    } memPort_t;

endpackage

`default_nettype wire

// ==== logic/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem
    import memPkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_ioFull,
    input  logic                  i_dataStb,
    input  dataReq_t              i_dataReq,
    input  logic                  i_fetchStart,
    input  logic [ADDR_WIDTH-1:0] i_fetchPc,
    input  logic                  i_instPop,
    output logic                  o_dataBusy,
    output dataResp_t             o_dataResp,
    output logic [31:0]           o_inst,
    output logic                  o_instValid
);

    memPort_t                memPort;
    logic [7:0]              rdByte;
    logic                    fetchReq;
    logic [ADDR_WIDTH-1:0]   fetchAddr;
    logic                    fetchDone;
    logic [31:0]             fetchInst;
    logic                    instPush;
    logic [31:0]             instData;
    logic                    queueFlush;
    logic [QCOUNT_WIDTH-1:0] queueCount;

    memCtrl uCtrl (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (i_ioFull),
        .i_dataStb   (i_dataStb),
        .i_dataReq   (i_dataReq),
        .i_fetchReq  (fetchReq),
        .i_fetchAddr (fetchAddr),
        .i_rdByte    (rdByte),
        .o_dataBusy  (o_dataBusy),
        .o_dataResp  (o_dataResp),
        .o_fetchDone (fetchDone),
        .o_fetchInst (fetchInst),
        .o_memPort   (memPort)
    );

    byteRam uRam (
        .clk      (clk),
        .i_port   (memPort),
        .o_rdByte (rdByte)
    );

    fetchUnit uFetch (
        .clk          (clk),
        .rst          (rst),
        .i_fetchStart (i_fetchStart),
        .i_fetchPc    (i_fetchPc),
        .i_fetchDone  (fetchDone),
        .i_fetchInst  (fetchInst),
        .i_queueCount (queueCount),
        .o_fetchReq   (fetchReq),
        .o_fetchAddr  (fetchAddr),
        .o_instPush   (instPush),
        .o_instData   (instData),
        .o_queueFlush (queueFlush)
    );

    instQueue uQueue (
        .clk        (clk),
        .rst        (rst),
        .i_push     (instPush),
        .i_pushData (instData),
        .i_pop      (i_instPop),
        .i_flush    (queueFlush),
        .o_head     (o_inst),
        .o_valid    (o_instValid),
        .o_count    (queueCount)
    );

endmodule

`default_nettype wire

// ==== testbench/tbMemSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMemSubsystem
    import memPkg::*;
();

    localparam int TIMEOUT = 300;

    typedef struct packed {
        dataReq_t    req;
        logic [31:0] expRd;
        logic [2:0]  group;
    } opEntry_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  ioFull;
    logic                  dataStb;
    dataReq_t              dataReq;
    logic                  fetchStart;
    logic [ADDR_WIDTH-1:0] fetchPc;
    logic                  instPop;
    logic                  dataBusy;
    dataResp_t             dataResp;
    logic [31:0]           inst;
    logic                  instValid;

    opEntry_t    opTable [$];
    // byte image of every store sent to the DUT
    logic [7:0]  model [RAM_DEPTH];
    logic [31:0] wordsA [12];
    logic [31:0] wordsB [8];
    int          errors;
    int          testsRun;
    int          testsFailed;

    memSubsystem i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_ioFull     (ioFull),
        .i_dataStb    (dataStb),
        .i_dataReq    (dataReq),
        .i_fetchStart (fetchStart),
        .i_fetchPc    (fetchPc),
        .i_instPop    (instPop),
        .o_dataBusy   (dataBusy),
        .o_dataResp   (dataResp),
        .o_inst       (inst),
        .o_instValid  (instValid)
    );

    always #10 clk = ~clk;

    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h at %0t",
                     name, expected, actual, $time);
            errors++;
        end
    endtask

    function automatic int byteCount(input memWidth_e width);
        case (width)
            WIDTH_BYTE: return 1;
            WIDTH_HALF: return 2;
            default:    return 4;
        endcase
    endfunction

    // little endian, zero extended
    function automatic logic [31:0] modelLoad(input logic [ADDR_WIDTH-1:0] addr,
                                              input memWidth_e width);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < byteCount(width); i++) begin
            w[8*i +: 8] = model[addr + i];
        end
        return w;
    endfunction

    task automatic modelStore(input logic [ADDR_WIDTH-1:0] addr, input memWidth_e width,
                              input logic [31:0] data);
        for (int i = 0; i < byteCount(width); i++) begin
            model[addr + i] = data[8*i +: 8];
        end
    endtask

    function automatic opEntry_t makeOp(input memOp_e op, input memWidth_e width,
                                        input logic [ADDR_WIDTH-1:0] addr,
                                        input logic [31:0] wrData,
                                        input logic [31:0] expRd, input logic [2:0] group);
        opEntry_t e;
        e.req.op = op;
        e.req.width = width;
        e.req.addr = addr;
        e.req.wrData = wrData;
        e.expRd = expRd;
        e.group = group;
        return e;
    endfunction

    task automatic fillTable();
        // group 1 round trips at 0x040
        opTable.push_back(makeOp(OP_STORE, WIDTH_WORD, 12'h040, 32'h89ABCDEF, 32'h0, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h040, 32'h0, 32'h89ABCDEF, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_HALF, 12'h042, 32'h0, 32'h000089AB, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_BYTE, 12'h041, 32'h0, 32'h000000CD, 3'd1));
        opTable.push_back(makeOp(OP_STORE, WIDTH_HALF, 12'h041, 32'h00001234, 32'h0, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h040, 32'h0, 32'h891234EF, 3'd1));
        opTable.push_back(makeOp(OP_STORE, WIDTH_BYTE, 12'h043, 32'h000000A5, 32'h0, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_HALF, 12'h042, 32'h0, 32'h0000A512, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h040, 32'h0, 32'hA51234EF, 3'd1));
        opTable.push_back(makeOp(OP_STORE, WIDTH_WORD, 12'h042, 32'h76543210, 32'h0, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h041, 32'h0, 32'h54321034, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_HALF, 12'h044, 32'h0, 32'h00007654, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_BYTE, 12'h045, 32'h0, 32'h00000076, 3'd1));
        opTable.push_back(makeOp(OP_STORE, WIDTH_BYTE, 12'h046, 32'hFFFFFF5A, 32'h0, 3'd1));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_HALF, 12'h045, 32'h0, 32'h00005A76, 3'd1));
        // group 2 latency of every width
        opTable.push_back(makeOp(OP_STORE, WIDTH_WORD, 12'h050, 32'h44332211, 32'h0, 3'd2));
        opTable.push_back(makeOp(OP_STORE, WIDTH_BYTE, 12'h054, 32'h00000077, 32'h0, 3'd2));
        opTable.push_back(makeOp(OP_STORE, WIDTH_HALF, 12'h056, 32'h00009988, 32'h0, 3'd2));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_BYTE, 12'h053, 32'h0, 32'h00000044, 3'd2));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_HALF, 12'h051, 32'h0, 32'h00003322, 3'd2));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h050, 32'h0, 32'h44332211, 3'd2));
        // group 3 loads under stall
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h042, 32'h0, 32'h76543210, 3'd3));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_HALF, 12'h040, 32'h0, 32'h000034EF, 3'd3));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_BYTE, 12'h046, 32'h0, 32'h0000005A, 3'd3));
        // group 6 data ops while fetching
        opTable.push_back(makeOp(OP_STORE, WIDTH_WORD, 12'h080, 32'hCAFE0123, 32'h0, 3'd6));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h080, 32'h0, 32'hCAFE0123, 3'd6));
        opTable.push_back(makeOp(OP_STORE, WIDTH_HALF, 12'h082, 32'h0000BEEF, 32'h0, 3'd6));
        opTable.push_back(makeOp(OP_LOAD,  WIDTH_WORD, 12'h080, 32'h0, 32'hBEEF0123, 3'd6));
    endtask

    // stall window covers cycles 2 .. stallCycles+1 after the sampling edge
    task automatic runDataOp(input opEntry_t e, input int stallCycles);
        int n;
        int expLat;
        logic [31:0] rd;
        expLat = byteCount(e.req.width) + ((e.req.op == OP_LOAD) ? 1 : 0) + stallCycles;
        n = 0;
        while (dataBusy !== 1'b0 && n < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end
        if (dataBusy !== 1'b0) begin
            $display("data port stayed busy, request to %h was not sent", e.req.addr);
            errors++;
            return;
        end
        @(posedge clk);
        dataStb <= 1'b1;
        dataReq <= e.req;
        @(posedge clk);
        dataStb <= 1'b0;
        n = 1;
        @(negedge clk);
        while (dataResp.done !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
            ioFull <= (n >= 2) && (n < 2 + stallCycles);
            @(negedge clk);
        end
        if (dataResp.done !== 1'b1) begin
            $display("no done pulse for the request to %h", e.req.addr);
            errors++;
            return;
        end
        rd = dataResp.rdData;
        checkVal("o_dataResp.done latency", expLat, 32'(n));
        if (e.req.op == OP_STORE) begin
            modelStore(e.req.addr, e.req.width, e.req.wrData);
            checkVal("o_dataResp.rdData", 32'h0, rd);
        end else begin
            checkVal("o_dataResp.rdData", modelLoad(e.req.addr, e.req.width), rd);
            checkVal("o_dataResp.rdData", e.expRd, rd);
        end
        @(posedge clk);
        @(negedge clk);
        // done is a single-cycle pulse
        checkVal("o_dataResp.done", 32'h0, 32'(dataResp.done));
        checkVal("o_dataBusy", 32'h0, 32'(dataBusy));
    endtask

    task automatic startFetch(input logic [ADDR_WIDTH-1:0] pc);
        @(posedge clk);
        fetchStart <= 1'b1;
        fetchPc <= pc;
        @(posedge clk);
        fetchStart <= 1'b0;
        @(negedge clk);
    endtask

    // fetch has stopped once the port idles longer than the gap between fetches
    task automatic waitQueueFull();
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (quiet < 4 && n < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            n++;
            quiet = (dataBusy === 1'b0 && instValid === 1'b1) ? quiet + 1 : 0;
        end
        if (quiet < 4) begin
            $display("fetch never settled with a full instruction queue");
            errors++;
        end
    endtask

    task automatic popCheck(input logic [31:0] expected);
        int n;
        n = 0;
        while (instValid !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end
        if (instValid !== 1'b1) begin
            $display("no valid instruction arrived in the queue");
            errors++;
            return;
        end
        checkVal("o_inst", expected, inst);
        @(posedge clk);
        instPop <= 1'b1;
        @(posedge clk);
        instPop <= 1'b0;
        @(negedge clk);
    endtask

    task automatic reportTest(input string name, input int errStart);
        testsRun++;
        if (errors == errStart) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d errors", testsRun, name, errors - errStart);
        end
    endtask

    initial begin
        int errStart;
        int stall;
        int nextB;
        rst = 1'b1;
        ioFull = 1'b0;
        dataStb = 1'b0;
        dataReq = '0;
        fetchStart = 1'b0;
        fetchPc = '0;
        instPop = 1'b0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        void'($urandom(32'h9718));
        fillTable();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        errStart = errors;
        foreach (opTable[i]) begin
            if (opTable[i].group == 3'd1) begin
                runDataOp(opTable[i], 0);
            end
        end
        reportTest("store and load round trips", errStart);

        errStart = errors;
        foreach (opTable[i]) begin
            if (opTable[i].group == 3'd2) begin
                runDataOp(opTable[i], 0);
            end
        end
        reportTest("load and store latency", errStart);

        errStart = errors;
        foreach (opTable[i]) begin
            if (opTable[i].group == 3'd3) begin
                stall = 1 + int'($urandom % 5);
                runDataOp(opTable[i], stall);
            end
        end
        reportTest("load under stall", errStart);

        errStart = errors;
        for (int i = 0; i < 12; i++) begin
            wordsA[i] = $urandom;
            runDataOp(makeOp(OP_STORE, WIDTH_WORD, 12'h100 + 12'(4 * i), wordsA[i],
                             32'h0, 3'd4), 0);
        end
        for (int i = 0; i < 8; i++) begin
            wordsB[i] = $urandom;
            runDataOp(makeOp(OP_STORE, WIDTH_WORD, 12'h200 + 12'(4 * i), wordsB[i],
                             32'h0, 3'd4), 0);
        end
        startFetch(12'h100);
        waitQueueFull();
        // drain back to back while the refill is still several cycles away
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            @(posedge clk);
            instPop <= 1'b1;
            @(negedge clk);
            checkVal("o_instValid", 32'h1, 32'(instValid));
            checkVal("o_inst", wordsA[i], inst);
        end
        @(posedge clk);
        instPop <= 1'b0;
        @(negedge clk);
        checkVal("o_instValid", 32'h0, 32'(instValid));
        for (int i = QUEUE_DEPTH; i < 8; i++) begin
            popCheck(wordsA[i]);
        end
        reportTest("sequential fetch", errStart);

        // the pop frees a slot, so a fetch is pending when the restart lands
        errStart = errors;
        waitQueueFull();
        popCheck(wordsA[8]);
        startFetch(12'h200);
        popCheck(wordsB[0]);
        reportTest("restart and flush", errStart);

        errStart = errors;
        nextB = 1;
        foreach (opTable[i]) begin
            if (opTable[i].group == 3'd6) begin
                waitQueueFull();
                popCheck(wordsB[nextB]);
                nextB++;
                runDataOp(opTable[i], 0);
            end
        end
        while (nextB < 8) begin
            popCheck(wordsB[nextB]);
            nextB++;
        end
        reportTest("data priority over fetch", errStart);

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/memPkg.sv
logic/byteRam.sv
logic/memCtrl.sv
logic/fetchUnit.sv
logic/instQueue.sv
logic/memSubsystem.sv
testbench/tbMemSubsystem.sv
